// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= id2_stage_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/id2_consts.svh ====
`ifndef ID2_CONSTS_SVH
`define ID2_CONSTS_SVH

`define ID2_XLEN        32
`define ID2_REG_AW      5
`define ID2_IMM_W       16
`define ID2_SA_W        5

// primary opcode field, inst[31:26]
`define OP_SPECIAL      6'b000000
`define OP_REGIMM       6'b000001
`define OP_BEQ          6'b000100
`define OP_BNE          6'b000101
`define OP_BLEZ         6'b000110
`define OP_BGTZ         6'b000111
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001
`define OP_SLTI         6'b001010
`define OP_SLTIU        6'b001011
`define OP_ANDI         6'b001100
`define OP_ORI          6'b001101
`define OP_XORI         6'b001110
`define OP_LUI          6'b001111

// function field of special, inst[5:0]
`define FN_ADD          6'b100000
`define FN_ADDU         6'b100001
`define FN_SUB          6'b100010
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111
`define FN_SLT          6'b101010
`define FN_SLTU         6'b101011
`define FN_SLL          6'b000000
`define FN_SRL          6'b000010
`define FN_SRA          6'b000011
`define FN_SLLV         6'b000100
`define FN_SRLV         6'b000110
`define FN_SRAV         6'b000111
`define FN_SYSCALL      6'b001100
`define FN_BREAK        6'b001101

// rt field of regimm
`define RT_BLTZ         5'b00000
`define RT_BGEZ         5'b00001
`define RT_BLTZAL       5'b10000
`define RT_BGEZAL       5'b10001

`define ID2_PC_STEP     32'd4

`endif

// ==== design/id2_pkg.sv ====
package id2_pkg;

    // rs and rt
    parameter int num_operands = 2;

    typedef enum logic [3:0] {
        alu_nop,
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic {
        src_a_rs,
        src_a_rt
    } src_a_sel_e;

    typedef enum logic [2:0] {
        src_b_nop,
        src_b_rt,
        src_b_imme,
        src_b_rs,
        src_b_sa
    } src_b_sel_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_bgezal,
        br_bltzal
    } branch_sel_e;

    typedef enum logic {
        res_alu,
        res_pc8
    } res_sel_e;

    // nop reads the register file
    typedef enum logic [2:0] {
        fwd_nop,
        fwd_exc_alu,
        fwd_exp_alu,
        fwd_memc_alu,
        fwd_memc_mem,
        fwd_memp_alu,
        fwd_memp_mem
    } fwd_sel_e;

endpackage

// ==== design/id2_stage.sv ====
`include "id2_consts.svh"

module id2_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic [`ID2_XLEN-1:0]     inst,
    input  logic [`ID2_XLEN-1:0]     pc,
    input  logic [`ID2_XLEN-1:0]     reg_r_data_1,
    input  logic [`ID2_XLEN-1:0]     reg_r_data_2,
    input  id2_pkg::fwd_sel_e        fwd_rs,
    input  id2_pkg::fwd_sel_e        fwd_rt,
    input  logic [`ID2_XLEN-1:0]     exc_alu_res,
    input  logic [`ID2_XLEN-1:0]     exp_alu_res,
    input  logic [`ID2_XLEN-1:0]     memc_alu_res,
    input  logic [`ID2_XLEN-1:0]     memc_r_data,
    input  logic [`ID2_XLEN-1:0]     memp_alu_res,
    input  logic [`ID2_XLEN-1:0]     memp_r_data,
    output logic [`ID2_REG_AW-1:0]   reg_r_addr_1,
    output logic [`ID2_REG_AW-1:0]   reg_r_addr_2,
    output logic                     out_valid,
    output id2_pkg::alu_op_e         id2_alu_op,
    output id2_pkg::src_a_sel_e      id2_src_a_sel,
    output id2_pkg::src_b_sel_e      id2_src_b_sel,
    output id2_pkg::res_sel_e        id2_res_sel,
    output id2_pkg::branch_sel_e     id2_branch_sel,
    output logic [`ID2_XLEN-1:0]     id2_ext_imme,
    output logic [`ID2_XLEN-1:0]     id2_branch_target,
    output logic                     id2_is_check_ov,
    output logic                     id2_is_ri,
    output logic                     id2_is_syscall,
    output logic                     id2_is_break,
    output logic [`ID2_REG_AW-1:0]   id2_rs,
    output logic [`ID2_REG_AW-1:0]   id2_rt,
    output logic [`ID2_REG_AW-1:0]   id2_rd,
    output logic [`ID2_SA_W-1:0]     id2_sa,
    output logic [`ID2_IMM_W-1:0]    id2_imme,
    output logic [`ID2_XLEN-1:0]     id2_pc,
    output logic [`ID2_XLEN-1:0]     id2_rs_data,
    output logic [`ID2_XLEN-1:0]     id2_rt_data
);

    id2_pkg::alu_op_e           alu_op;
    id2_pkg::src_a_sel_e        src_a_sel;
    id2_pkg::src_b_sel_e        src_b_sel;
    id2_pkg::res_sel_e          res_sel;
    id2_pkg::branch_sel_e       branch_sel;
    logic [`ID2_XLEN-1:0]       ext_imme;
    logic [`ID2_XLEN-1:0]       branch_target;
    logic                       is_check_ov;
    logic                       is_ri;
    logic                       is_syscall;
    logic                       is_break;
    logic [`ID2_REG_AW-1:0]     rs;
    logic [`ID2_REG_AW-1:0]     rt;
    logic [`ID2_REG_AW-1:0]     rd;
    logic [`ID2_SA_W-1:0]       sa;
    logic [`ID2_IMM_W-1:0]      imme;
    logic [`ID2_XLEN-1:0]       rs_data;
    logic [`ID2_XLEN-1:0]       rt_data;

    id2_pkg::fwd_sel_e          fwd_sel  [id2_pkg::num_operands];
    logic [`ID2_XLEN-1:0]       reg_data [id2_pkg::num_operands];
    logic [`ID2_XLEN-1:0]       operand  [id2_pkg::num_operands];

    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign imme = inst[15:0];

    // register file read ports, same cycle
    assign reg_r_addr_1 = rs;
    assign reg_r_addr_2 = rt;

    // index 0 is rs, 1 is rt
    assign fwd_sel[0]  = fwd_rs;
    assign fwd_sel[1]  = fwd_rt;
    assign reg_data[0] = reg_r_data_1;
    assign reg_data[1] = reg_r_data_2;
    assign rs_data     = operand[0];
    assign rt_data     = operand[1];

    inst_classifier u_classifier (.*);

    for (genvar i = 0; i < id2_pkg::num_operands; i++) begin : g_fwd
        operand_forward u_fwd (
            .sel          (fwd_sel[i]),
            .reg_data     (reg_data[i]),
            .exc_alu_res  (exc_alu_res),
            .exp_alu_res  (exp_alu_res),
            .memc_alu_res (memc_alu_res),
            .memc_r_data  (memc_r_data),
            .memp_alu_res (memp_alu_res),
            .memp_r_data  (memp_r_data),
            .operand      (operand[i])
        );
    end

    id2_stage_reg u_stage_reg (.*);

endmodule

// ==== design/id2_stage_reg.sv ====
`include "id2_consts.svh"

module id2_stage_reg (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  id2_pkg::alu_op_e         alu_op,
    input  id2_pkg::src_a_sel_e      src_a_sel,
    input  id2_pkg::src_b_sel_e      src_b_sel,
    input  id2_pkg::res_sel_e        res_sel,
    input  id2_pkg::branch_sel_e     branch_sel,
    input  logic [`ID2_XLEN-1:0]     ext_imme,
    input  logic [`ID2_XLEN-1:0]     branch_target,
    input  logic                     is_check_ov,
    input  logic                     is_ri,
    input  logic                     is_syscall,
    input  logic                     is_break,
    input  logic [`ID2_REG_AW-1:0]   rs,
    input  logic [`ID2_REG_AW-1:0]   rt,
    input  logic [`ID2_REG_AW-1:0]   rd,
    input  logic [`ID2_SA_W-1:0]     sa,
    input  logic [`ID2_IMM_W-1:0]    imme,
    input  logic [`ID2_XLEN-1:0]     pc,
    input  logic [`ID2_XLEN-1:0]     rs_data,
    input  logic [`ID2_XLEN-1:0]     rt_data,
    output logic                     out_valid,
    output id2_pkg::alu_op_e         id2_alu_op,
    output id2_pkg::src_a_sel_e      id2_src_a_sel,
    output id2_pkg::src_b_sel_e      id2_src_b_sel,
    output id2_pkg::res_sel_e        id2_res_sel,
    output id2_pkg::branch_sel_e     id2_branch_sel,
    output logic [`ID2_XLEN-1:0]     id2_ext_imme,
    output logic [`ID2_XLEN-1:0]     id2_branch_target,
    output logic                     id2_is_check_ov,
    output logic                     id2_is_ri,
    output logic                     id2_is_syscall,
    output logic                     id2_is_break,
    output logic [`ID2_REG_AW-1:0]   id2_rs,
    output logic [`ID2_REG_AW-1:0]   id2_rt,
    output logic [`ID2_REG_AW-1:0]   id2_rd,
    output logic [`ID2_SA_W-1:0]     id2_sa,
    output logic [`ID2_IMM_W-1:0]    id2_imme,
    output logic [`ID2_XLEN-1:0]     id2_pc,
    output logic [`ID2_XLEN-1:0]     id2_rs_data,
    output logic [`ID2_XLEN-1:0]     id2_rt_data
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid         <= 1'b0;
            id2_alu_op        <= id2_pkg::alu_nop;
            id2_src_a_sel     <= id2_pkg::src_a_rs;
            id2_src_b_sel     <= id2_pkg::src_b_nop;
            id2_res_sel       <= id2_pkg::res_alu;
            id2_branch_sel    <= id2_pkg::br_none;
            id2_ext_imme      <= '0;
            id2_branch_target <= '0;
            id2_is_check_ov   <= 1'b0;
            id2_is_ri         <= 1'b0;
            id2_is_syscall    <= 1'b0;
            id2_is_break      <= 1'b0;
            id2_rs            <= '0;
            id2_rt            <= '0;
            id2_rd            <= '0;
            id2_sa            <= '0;
            id2_imme          <= '0;
            id2_pc            <= '0;
            id2_rs_data       <= '0;
            id2_rt_data       <= '0;
        end else begin
            // loads every cycle, a bubble only drops valid and flags
            out_valid         <= in_valid;
            id2_alu_op        <= alu_op;
            id2_src_a_sel     <= src_a_sel;
            id2_src_b_sel     <= src_b_sel;
            id2_res_sel       <= res_sel;
            id2_branch_sel    <= branch_sel;
            id2_ext_imme      <= ext_imme;
            id2_branch_target <= branch_target;
            id2_is_check_ov   <= is_check_ov;
            id2_is_ri         <= in_valid & is_ri;
            id2_is_syscall    <= in_valid & is_syscall;
            id2_is_break      <= in_valid & is_break;
            id2_rs            <= rs;
            id2_rt            <= rt;
            id2_rd            <= rd;
            id2_sa            <= sa;
            id2_imme          <= imme;
            id2_pc            <= pc;
            id2_rs_data       <= rs_data;
            id2_rt_data       <= rt_data;
        end
    end

endmodule

// ==== design/inst_classifier.sv ====
`include "id2_consts.svh"

module inst_classifier (
    input  logic [`ID2_XLEN-1:0]     inst,
    input  logic [`ID2_XLEN-1:0]     pc,
    input  logic                     in_valid,
    output id2_pkg::alu_op_e         alu_op,
    output id2_pkg::src_a_sel_e      src_a_sel,
    output id2_pkg::src_b_sel_e      src_b_sel,
    output id2_pkg::res_sel_e        res_sel,
    output id2_pkg::branch_sel_e     branch_sel,
    output logic [`ID2_XLEN-1:0]     ext_imme,
    output logic [`ID2_XLEN-1:0]     branch_target,
    output logic                     is_check_ov,
    output logic                     is_ri,
    output logic                     is_syscall,
    output logic                     is_break
);

    logic [5:0]                 opcode;
    logic [5:0]                 func;
    logic [`ID2_REG_AW-1:0]     rt;
    logic [`ID2_IMM_W-1:0]      imme;
    logic                       is_special;
    logic                       known;
    logic                       syscall_hit;
    logic                       break_hit;
    logic                       sign_ext;
    logic                       imm_form;
    logic                       shift_op;
    logic                       var_shift;

    assign opcode     = inst[31:26];
    assign rt         = inst[20:16];
    assign imme       = inst[15:0];
    assign func       = inst[5:0];
    assign is_special = (opcode == `OP_SPECIAL);

    // opcode, function and regimm rt to operation and branch type
    always_comb begin
        alu_op      = id2_pkg::alu_nop;
        branch_sel  = id2_pkg::br_none;
        known       = 1'b1;
        syscall_hit = 1'b0;
        break_hit   = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                case (func)
                    `FN_ADD, `FN_ADDU:   alu_op = id2_pkg::alu_add;
                    `FN_SUB, `FN_SUBU:   alu_op = id2_pkg::alu_sub;
                    `FN_SLT:             alu_op = id2_pkg::alu_slt;
                    `FN_SLTU:            alu_op = id2_pkg::alu_sltu;
                    `FN_AND:             alu_op = id2_pkg::alu_and;
                    `FN_OR:              alu_op = id2_pkg::alu_or;
                    `FN_XOR:             alu_op = id2_pkg::alu_xor;
                    `FN_NOR:             alu_op = id2_pkg::alu_nor;
                    `FN_SLL, `FN_SLLV:   alu_op = id2_pkg::alu_sll;
                    `FN_SRL, `FN_SRLV:   alu_op = id2_pkg::alu_srl;
                    `FN_SRA, `FN_SRAV:   alu_op = id2_pkg::alu_sra;
                    `FN_SYSCALL:         syscall_hit = 1'b1;
                    `FN_BREAK:           break_hit = 1'b1;
                    default:             known = 1'b0;
                endcase
            end
            `OP_ADDI, `OP_ADDIU:    alu_op = id2_pkg::alu_add;
            `OP_SLTI:               alu_op = id2_pkg::alu_slt;
            `OP_SLTIU:              alu_op = id2_pkg::alu_sltu;
            `OP_ANDI:               alu_op = id2_pkg::alu_and;
            `OP_ORI:                alu_op = id2_pkg::alu_or;
            `OP_XORI:               alu_op = id2_pkg::alu_xor;
            `OP_LUI:                alu_op = id2_pkg::alu_lui;
            `OP_BEQ:                branch_sel = id2_pkg::br_beq;
            `OP_BNE:                branch_sel = id2_pkg::br_bne;
            `OP_BLEZ:               branch_sel = id2_pkg::br_blez;
            `OP_BGTZ:               branch_sel = id2_pkg::br_bgtz;
            `OP_REGIMM: begin
                case (rt)
                    `RT_BLTZ:       branch_sel = id2_pkg::br_bltz;
                    `RT_BGEZ:       branch_sel = id2_pkg::br_bgez;
                    `RT_BLTZAL:     branch_sel = id2_pkg::br_bltzal;
                    `RT_BGEZAL:     branch_sel = id2_pkg::br_bgezal;
                    default:        known = 1'b0;
                endcase
            end
            default:                known = 1'b0;
        endcase
    end

    assign sign_ext = (opcode == `OP_ADDI) || (opcode == `OP_ADDIU) ||
                      (opcode == `OP_SLTI) || (opcode == `OP_SLTIU);
    assign imm_form = sign_ext || (opcode == `OP_ANDI) || (opcode == `OP_ORI) ||
                      (opcode == `OP_XORI) || (opcode == `OP_LUI);

    assign shift_op  = is_special && ((alu_op == id2_pkg::alu_sll) ||
                       (alu_op == id2_pkg::alu_srl) || (alu_op == id2_pkg::alu_sra));
    assign var_shift = is_special && ((func == `FN_SLLV) || (func == `FN_SRLV) ||
                       (func == `FN_SRAV));

    // shifts take the value from rt, amount from sa or rs
    always_comb begin
        src_a_sel = shift_op ? id2_pkg::src_a_rt : id2_pkg::src_a_rs;
        if (shift_op) begin
            src_b_sel = var_shift ? id2_pkg::src_b_rs : id2_pkg::src_b_sa;
        end else if (imm_form) begin
            src_b_sel = id2_pkg::src_b_imme;
        end else if (is_special && (alu_op != id2_pkg::alu_nop)) begin
            src_b_sel = id2_pkg::src_b_rt;
        end else begin
            src_b_sel = id2_pkg::src_b_nop;
        end
    end

    // link branches write pc + 8
    assign res_sel = ((branch_sel == id2_pkg::br_bgezal) || (branch_sel == id2_pkg::br_bltzal)) ?
                     id2_pkg::res_pc8 : id2_pkg::res_alu;

    assign is_check_ov = (is_special && ((func == `FN_ADD) || (func == `FN_SUB))) ||
                         (opcode == `OP_ADDI);

    assign ext_imme = sign_ext ? {{(`ID2_XLEN-`ID2_IMM_W){imme[`ID2_IMM_W-1]}}, imme} :
                                 {{(`ID2_XLEN-`ID2_IMM_W){1'b0}}, imme};

    assign branch_target = pc + `ID2_PC_STEP +
                           {{(`ID2_XLEN-`ID2_IMM_W-2){imme[`ID2_IMM_W-1]}}, imme, 2'b00};

    assign is_ri      = in_valid & ~known;
    assign is_syscall = in_valid & syscall_hit;
    assign is_break   = in_valid & break_hit;

endmodule

// ==== design/operand_forward.sv ====
`include "id2_consts.svh"

module operand_forward (
    input  id2_pkg::fwd_sel_e        sel,
    input  logic [`ID2_XLEN-1:0]     reg_data,
    input  logic [`ID2_XLEN-1:0]     exc_alu_res,
    input  logic [`ID2_XLEN-1:0]     exp_alu_res,
    input  logic [`ID2_XLEN-1:0]     memc_alu_res,
    input  logic [`ID2_XLEN-1:0]     memc_r_data,
    input  logic [`ID2_XLEN-1:0]     memp_alu_res,
    input  logic [`ID2_XLEN-1:0]     memp_r_data,
    output logic [`ID2_XLEN-1:0]     operand
);

    always_comb begin
        case (sel)
            id2_pkg::fwd_nop:       operand = reg_data;
            id2_pkg::fwd_exc_alu:   operand = exc_alu_res;
            id2_pkg::fwd_exp_alu:   operand = exp_alu_res;
            id2_pkg::fwd_memc_alu:  operand = memc_alu_res;
            id2_pkg::fwd_memc_mem:  operand = memc_r_data;
            id2_pkg::fwd_memp_alu:  operand = memp_alu_res;
            id2_pkg::fwd_memp_mem:  operand = memp_r_data;
            // unused code 7
            default:                operand = '0;
        endcase
    end

endmodule

// ==== sim.f ====
+incdir+design
+incdir+verif
design/id2_pkg.sv
design/inst_classifier.sv
design/operand_forward.sv
design/id2_stage_reg.sv
design/id2_stage.sv
verif/id2_stage_tb.sv

// ==== verif/id2_ref_model.svh ====
`ifndef ID2_REF_MODEL_SVH
`define ID2_REF_MODEL_SVH

// one registered output set of the stage, field order matches the port list
typedef struct packed {
    logic                       valid;
    id2_pkg::alu_op_e           alu_op;
    id2_pkg::src_a_sel_e        src_a_sel;
    id2_pkg::src_b_sel_e        src_b_sel;
    id2_pkg::res_sel_e          res_sel;
    id2_pkg::branch_sel_e       branch_sel;
    logic [`ID2_XLEN-1:0]       ext_imme;
    logic [`ID2_XLEN-1:0]       branch_target;
    logic                       is_check_ov;
    logic                       is_ri;
    logic                       is_syscall;
    logic                       is_break;
    logic [`ID2_REG_AW-1:0]     rs;
    logic [`ID2_REG_AW-1:0]     rt;
    logic [`ID2_REG_AW-1:0]     rd;
    logic [`ID2_SA_W-1:0]       sa;
    logic [`ID2_IMM_W-1:0]      imme;
    logic [`ID2_XLEN-1:0]       pc;
    logic [`ID2_XLEN-1:0]       rs_data;
    logic [`ID2_XLEN-1:0]       rt_data;
} id2_out_t;

// bypass[0] is exc_alu_res up to bypass[5] for memp_r_data
function automatic logic [`ID2_XLEN-1:0] pick_source(input logic [2:0] code,
        input logic [`ID2_XLEN-1:0] reg_val, input logic [5:0][`ID2_XLEN-1:0] bypass);
    if (code == 3'd0) begin
        return reg_val;
    end
    if (code == 3'd7) begin
        return '0;
    end
    return bypass[code - 3'd1];
endfunction

function automatic id2_out_t id2_ref(
    input logic                         valid,
    input logic [`ID2_XLEN-1:0]         word,
    input logic [`ID2_XLEN-1:0]         pc_in,
    input logic [`ID2_XLEN-1:0]         rs_reg,
    input logic [`ID2_XLEN-1:0]         rt_reg,
    input logic [2:0]                   rs_code,
    input logic [2:0]                   rt_code,
    input logic [5:0][`ID2_XLEN-1:0]    bypass
);
    logic [5:0]             op;
    logic [5:0]             fn;
    logic [`ID2_XLEN-1:0]   sext;
    id2_out_t               e;

    op   = word[31:26];
    fn   = word[5:0];
    sext = {{16{word[15]}}, word[15:0]};
    e    = '0;
    e.valid         = valid;
    e.rs            = word[25:21];
    e.rt            = word[20:16];
    e.rd            = word[15:11];
    e.sa            = word[10:6];
    e.imme          = word[15:0];
    e.pc            = pc_in;
    e.ext_imme      = {16'h0, word[15:0]};
    e.branch_target = pc_in + `ID2_PC_STEP + {sext[29:0], 2'b00};
    e.rs_data       = pick_source(rs_code, rs_reg, bypass);
    e.rt_data       = pick_source(rt_code, rt_reg, bypass);

    if (op == `OP_SPECIAL) begin
        case (fn)
            `FN_ADD, `FN_ADDU:              e.alu_op = id2_pkg::alu_add;
            `FN_SUB, `FN_SUBU:              e.alu_op = id2_pkg::alu_sub;
            `FN_SLT:                        e.alu_op = id2_pkg::alu_slt;
            `FN_SLTU:                       e.alu_op = id2_pkg::alu_sltu;
            `FN_AND:                        e.alu_op = id2_pkg::alu_and;
            `FN_OR:                         e.alu_op = id2_pkg::alu_or;
            `FN_XOR:                        e.alu_op = id2_pkg::alu_xor;
            `FN_NOR:                        e.alu_op = id2_pkg::alu_nor;
            `FN_SLL, `FN_SLLV:              e.alu_op = id2_pkg::alu_sll;
            `FN_SRL, `FN_SRLV:              e.alu_op = id2_pkg::alu_srl;
            `FN_SRA, `FN_SRAV:              e.alu_op = id2_pkg::alu_sra;
            `FN_SYSCALL:                    e.is_syscall = 1'b1;
            `FN_BREAK:                      e.is_break = 1'b1;
            default:                        e.is_ri = 1'b1;
        endcase
        e.is_check_ov = (fn == `FN_ADD) || (fn == `FN_SUB);
        // shift functions all sit below 6'b001000, bit 2 marks the variable ones
        if (e.alu_op != id2_pkg::alu_nop && fn[5:3] == 3'b000) begin
            e.src_a_sel = id2_pkg::src_a_rt;
            if (fn[2]) begin
                e.src_b_sel = id2_pkg::src_b_rs;
            end else begin
                e.src_b_sel = id2_pkg::src_b_sa;
            end
        end else if (e.alu_op != id2_pkg::alu_nop) begin
            e.src_b_sel = id2_pkg::src_b_rt;
        end
    end else if (op[5:3] == 3'b001) begin
        // addi up to lui
        e.src_b_sel   = id2_pkg::src_b_imme;
        e.is_check_ov = (op == `OP_ADDI);
        if (!op[2]) begin
            e.ext_imme = sext;
        end
        case (op[2:0])
            3'd0, 3'd1:     e.alu_op = id2_pkg::alu_add;
            3'd2:           e.alu_op = id2_pkg::alu_slt;
            3'd3:           e.alu_op = id2_pkg::alu_sltu;
            3'd4:           e.alu_op = id2_pkg::alu_and;
            3'd5:           e.alu_op = id2_pkg::alu_or;
            3'd6:           e.alu_op = id2_pkg::alu_xor;
            default:        e.alu_op = id2_pkg::alu_lui;
        endcase
    end else if (op == `OP_REGIMM) begin
        case (word[20:16])
            `RT_BLTZ:       e.branch_sel = id2_pkg::br_bltz;
            `RT_BGEZ:       e.branch_sel = id2_pkg::br_bgez;
            `RT_BLTZAL:     e.branch_sel = id2_pkg::br_bltzal;
            `RT_BGEZAL:     e.branch_sel = id2_pkg::br_bgezal;
            default:        e.is_ri = 1'b1;
        endcase
    end else if (op[5:2] == 4'b0001) begin
        case (op[1:0])
            2'd0:           e.branch_sel = id2_pkg::br_beq;
            2'd1:           e.branch_sel = id2_pkg::br_bne;
            2'd2:           e.branch_sel = id2_pkg::br_blez;
            default:        e.branch_sel = id2_pkg::br_bgtz;
        endcase
    end else begin
        e.is_ri = 1'b1;
    end

    // linking branches return pc + 8
    if (e.branch_sel == id2_pkg::br_bgezal || e.branch_sel == id2_pkg::br_bltzal) begin
        e.res_sel = id2_pkg::res_pc8;
    end
    e.is_ri      = e.is_ri & valid;
    e.is_syscall = e.is_syscall & valid;
    e.is_break   = e.is_break & valid;
    return e;
endfunction

`endif

// ==== verif/id2_stage_tb.sv ====
`include "id2_consts.svh"

module id2_stage_tb;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 8;
    localparam int n_kept       = 34;
    localparam int n_rand       = 400;
    // bubble after reset, table sweep, random mix, closing bubble
    localparam int n_vec        = 1 + n_kept + n_rand + 1;

    localparam logic [5:0] fn_list [18] = '{
        `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT,
        `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_SYSCALL, `FN_BREAK
    };
    localparam logic [5:0] op_list [12] = '{
        `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
        `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ
    };
    localparam logic [4:0] rt_list [4] = '{`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL};

    `include "id2_ref_model.svh"

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       in_valid;
    logic [`ID2_XLEN-1:0]       inst, pc, reg_r_data_1, reg_r_data_2;
    id2_pkg::fwd_sel_e          fwd_rs, fwd_rt;
    logic [`ID2_XLEN-1:0]       exc_alu_res, exp_alu_res, memc_alu_res;
    logic [`ID2_XLEN-1:0]       memc_r_data, memp_alu_res, memp_r_data;
    logic [`ID2_REG_AW-1:0]     reg_r_addr_1, reg_r_addr_2;
    logic                       out_valid;
    id2_pkg::alu_op_e           id2_alu_op;
    id2_pkg::src_a_sel_e        id2_src_a_sel;
    id2_pkg::src_b_sel_e        id2_src_b_sel;
    id2_pkg::res_sel_e          id2_res_sel;
    id2_pkg::branch_sel_e       id2_branch_sel;
    logic [`ID2_XLEN-1:0]       id2_ext_imme, id2_branch_target;
    logic                       id2_is_check_ov, id2_is_ri, id2_is_syscall, id2_is_break;
    logic [`ID2_REG_AW-1:0]     id2_rs, id2_rt, id2_rd;
    logic [`ID2_SA_W-1:0]       id2_sa;
    logic [`ID2_IMM_W-1:0]      id2_imme;
    logic [`ID2_XLEN-1:0]       id2_pc, id2_rs_data, id2_rt_data;

    int                         seed = 32'h9a19_9718;
    int                         checks = 0;
    // fixed bits of each kept instruction, and which bits stay fixed
    logic [`ID2_XLEN-1:0]       tmpl_word [$];
    logic [`ID2_XLEN-1:0]       tmpl_keep [$];

    id2_stage uut (.*);

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [`ID2_XLEN-1:0] fill_fields(input logic [`ID2_XLEN-1:0] fixed,
                                                        input logic [`ID2_XLEN-1:0] keep);
        return (fixed & keep) | ($random(seed) & ~keep);
    endfunction

    task automatic drive(input logic v, input logic [`ID2_XLEN-1:0] word,
                         input logic [2:0] rs_code, input logic [2:0] rt_code);
        @(posedge clk);
        in_valid     <= v;
        inst         <= word;
        pc           <= $random(seed) & 32'hffff_fffc;
        reg_r_data_1 <= $random(seed);
        reg_r_data_2 <= $random(seed);
        exc_alu_res  <= $random(seed);
        exp_alu_res  <= $random(seed);
        memc_alu_res <= $random(seed);
        memc_r_data  <= $random(seed);
        memp_alu_res <= $random(seed);
        memp_r_data  <= $random(seed);
        fwd_rs       <= id2_pkg::fwd_sel_e'(rs_code);
        fwd_rt       <= id2_pkg::fwd_sel_e'(rt_code);
    endtask

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    initial begin
        logic [`ID2_XLEN-1:0]   word;
        int                     k;

        arst_n       = 1'b0;
        in_valid     = 1'b0;
        inst         = '0;
        pc           = '0;
        reg_r_data_1 = '0;
        reg_r_data_2 = '0;
        fwd_rs       = id2_pkg::fwd_nop;
        fwd_rt       = id2_pkg::fwd_nop;
        exc_alu_res  = '0;
        exp_alu_res  = '0;
        memc_alu_res = '0;
        memc_r_data  = '0;
        memp_alu_res = '0;
        memp_r_data  = '0;
        foreach (fn_list[i]) begin
            tmpl_word.push_back({`OP_SPECIAL, 20'h0, fn_list[i]});
            tmpl_keep.push_back(32'hfc00_003f);
        end
        foreach (op_list[i]) begin
            tmpl_word.push_back({op_list[i], 26'h0});
            tmpl_keep.push_back(32'hfc00_0000);
        end
        foreach (rt_list[i]) begin
            tmpl_word.push_back({`OP_REGIMM, 5'h0, rt_list[i], 16'h0});
            tmpl_keep.push_back(32'hfc1f_0000);
        end

        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        // syscall in a bubble must not raise its flag
        drive(1'b0, {`OP_SPECIAL, 20'h0, `FN_SYSCALL}, 3'd0, 3'd0);
        // every kept instruction once while forwarding codes walk through all eight
        for (int i = 0; i < n_kept; i++) begin
            drive(1'b1, fill_fields(tmpl_word[i], tmpl_keep[i]), 3'(i), 3'(i + 3));
        end
        repeat (n_rand) begin
            if ({$random(seed)} % 4 == 0) begin
                word = $random(seed);
            end else begin
                k    = {$random(seed)} % tmpl_word.size();
                word = fill_fields(tmpl_word[k], tmpl_keep[k]);
            end
            drive({$random(seed)} % 8 != 0, word, 3'($random(seed)), 3'($random(seed)));
        end
        drive(1'b0, '0, 3'd0, 3'd0);
        repeat (3) @(posedge clk);
        if (checks > 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "no output was ever compared");
        end
    end

    // outputs at a falling edge hold what the inputs of the previous one asked for
    initial begin
        id2_out_t   got;
        id2_out_t   exp_q;

        exp_q = '0;
        forever begin
            @(negedge clk);
            got = '{out_valid, id2_alu_op, id2_src_a_sel, id2_src_b_sel, id2_res_sel,
                    id2_branch_sel, id2_ext_imme, id2_branch_target, id2_is_check_ov,
                    id2_is_ri, id2_is_syscall, id2_is_break, id2_rs, id2_rt, id2_rd,
                    id2_sa, id2_imme, id2_pc, id2_rs_data, id2_rt_data};
            assert (got === exp_q)
                else report_error($sformatf("outputs %h, expected %h", got, exp_q));
            assert (reg_r_addr_1 === inst[25:21] && reg_r_addr_2 === inst[20:16])
                else report_error($sformatf("read addresses %h %h for inst %h",
                                            reg_r_addr_1, reg_r_addr_2, inst));
            checks++;
            if (arst_n) begin
                exp_q = id2_ref(in_valid, inst, pc, reg_r_data_1, reg_r_data_2, fwd_rs,
                                fwd_rt, {memp_r_data, memp_alu_res, memc_r_data,
                                         memc_alu_res, exp_alu_res, exc_alu_res});
            end else begin
                exp_q = '0;
            end
        end
    end

    initial begin
        #((reset_cycles + n_vec + 20) * clk_period);
        $display("test failed");
        $fatal(1, "the run timed out before all vectors were checked");
    end

endmodule
